/* source/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;

    // operations kept from RV32I
    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_addi,
        op_lui,
        op_lw,
        op_sw,
        op_beq,
        op_bne,
        op_jal
    } op_t;

    // first fetch address
    localparam addr_t reset_pc = 32'h0000_0000;

    // major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // funct7 of register ops
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // funct3 of register and immediate ops
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 of loads, stores and branches
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

endpackage

/* source/rv_stage_if.sv */
`timescale 1ns/100ps

// decode to execute
interface issue_if import rv_pkg::*; ();
    logic      valid;
    op_t       op;
    addr_t     pc;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;

    modport issuer (output valid, op, pc, rd, rs1_data, rs2_data, imm);
    modport executor (input valid, op, pc, rd, rs1_data, rs2_data, imm);
    // hazard check only needs the destination
    modport observer (input valid, rd);
endinterface

// execute to memory access
interface mem_stage_if import rv_pkg::*; ();
    logic      valid;
    op_t       op;
    reg_addr_t rd;
    word_t     result;
    word_t     store_data;

    modport sender (output valid, op, rd, result, store_data);
    modport receiver (input valid, op, rd, result, store_data);
    modport observer (input valid, op, rd, result);
endinterface

/* source/fetch.sv */
`timescale 1ns/100ps

module fetch import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  pipe_hold,
    input  logic  decode_stall,
    input  logic  flush,
    input  addr_t flush_pc,
    output logic  inst_rden,
    output addr_t inst_raddr,
    input  logic  inst_rvalid,
    input  word_t inst_rdata,
    output logic  fetch_valid,
    output addr_t fetch_pc,
    output word_t fetch_inst
);

    logic  started;
    addr_t pc;
    logic  pending;
    addr_t pending_pc;
    logic  buf_valid;
    addr_t buf_pc;
    word_t buf_inst;
    logic  consume;
    logic  keep;

    // responses seen during a flush belong to squashed requests
    assign fetch_valid = !flush && (buf_valid || (pending && inst_rvalid));
    assign fetch_pc    = buf_valid ? buf_pc : pending_pc;
    assign fetch_inst  = buf_valid ? buf_inst : inst_rdata;

    assign consume = fetch_valid && !decode_stall && !pipe_hold;
    assign keep    = fetch_valid && !consume;

    // new request only if nothing will sit in the buffer afterwards
    assign inst_rden  = started && !pipe_hold &&
                        (flush || (!keep && (!pending || inst_rvalid)));
    assign inst_raddr = flush ? flush_pc : pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started   <= 1'b0;
            pc        <= reset_pc;
            pending   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            started   <= 1'b1;
            pending   <= inst_rden || (pending && !inst_rvalid);
            buf_valid <= keep;
            if (inst_rden) begin
                pc <= inst_raddr + 32'd4;
            end else if (flush) begin
                pc <= flush_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_rden) begin
            pending_pc <= inst_raddr;
        end
        // park the response while decode cannot take it
        if (keep && !buf_valid) begin
            buf_pc   <= pending_pc;
            buf_inst <= inst_rdata;
        end
    end

endmodule

/* source/decode.sv */
`timescale 1ns/100ps

module decode import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pipe_hold,
    input  logic      flush,
    input  logic      fetch_valid,
    input  addr_t     fetch_pc,
    input  word_t     fetch_inst,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  logic      rs1_valid,
    input  logic      rs2_valid,
    output logic      decode_stall,
    issue_if.issuer   issue
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_t        dec_op;
    word_t      dec_imm;
    reg_addr_t  dec_rd;
    logic       writes_rd;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode   = fetch_inst[6:0];
    assign funct3   = fetch_inst[14:12];
    assign funct7   = fetch_inst[31:25];
    assign rs1_addr = fetch_inst[19:15];
    assign rs2_addr = fetch_inst[24:20];

    always_comb begin
        dec_op  = op_nop;
        dec_imm = '0;
        case (opcode)
            opc_op: begin
                if (funct7 == f7_base) begin
                    case (funct3)
                        f3_add_sub: dec_op = op_add;
                        f3_slt:     dec_op = op_slt;
                        f3_xor:     dec_op = op_xor;
                        f3_or:      dec_op = op_or;
                        f3_and:     dec_op = op_and;
                        default:    dec_op = op_nop;
                    endcase
                end else if (funct7 == f7_alt && funct3 == f3_add_sub) begin
                    dec_op = op_sub;
                end
            end
            opc_op_imm: begin
                if (funct3 == f3_add_sub) begin
                    dec_op = op_addi;
                end
                dec_imm = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
            end
            opc_load: begin
                if (funct3 == f3_word) begin
                    dec_op = op_lw;
                end
                dec_imm = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
            end
            opc_store: begin
                if (funct3 == f3_word) begin
                    dec_op = op_sw;
                end
                dec_imm = {{20{fetch_inst[31]}}, fetch_inst[31:25], fetch_inst[11:7]};
            end
            opc_branch: begin
                if (funct3 == f3_beq) begin
                    dec_op = op_beq;
                end else if (funct3 == f3_bne) begin
                    dec_op = op_bne;
                end
                dec_imm = {{19{fetch_inst[31]}}, fetch_inst[31], fetch_inst[7],
                           fetch_inst[30:25], fetch_inst[11:8], 1'b0};
            end
            opc_jal: begin
                dec_op  = op_jal;
                dec_imm = {{11{fetch_inst[31]}}, fetch_inst[31], fetch_inst[19:12],
                           fetch_inst[20], fetch_inst[30:21], 1'b0};
            end
            opc_lui: begin
                dec_op  = op_lui;
                dec_imm = {fetch_inst[31:12], 12'b0};
            end
            default: dec_op = op_nop;
        endcase
    end

    // rd of zero marks an instruction with no register result
    assign writes_rd = !(dec_op inside {op_nop, op_sw, op_beq, op_bne});
    assign dec_rd    = writes_rd ? fetch_inst[11:7] : '0;

    assign use_rs1 = !(dec_op inside {op_nop, op_lui, op_jal});
    assign use_rs2 = dec_op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt,
                                    op_sw, op_beq, op_bne};

    assign decode_stall = fetch_valid &&
                          ((use_rs1 && !rs1_valid) || (use_rs2 && !rs2_valid));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
        end else if (!pipe_hold) begin
            // bubble on stall or flush
            issue.valid <= fetch_valid && !decode_stall && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipe_hold) begin
            issue.op       <= dec_op;
            issue.pc       <= fetch_pc;
            issue.rd       <= dec_rd;
            issue.rs1_data <= rs1_data;
            issue.rs2_data <= rs2_data;
            issue.imm      <= dec_imm;
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  reg_addr_t      rs1_addr,
    input  reg_addr_t      rs2_addr,
    output word_t          rs1_data,
    output word_t          rs2_data,
    output logic           rs1_valid,
    output logic           rs2_valid,
    input  logic           wb_en,
    input  reg_addr_t      wb_rd,
    input  word_t          wb_data,
    issue_if.observer      issue,
    mem_stage_if.observer  mem_stage
);

    word_t regs [32];

    // write-back carries the memory stage result, so it bypasses the array
    function automatic word_t read_data(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_en && wb_rd == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    function automatic logic read_valid(reg_addr_t addr);
        if (addr == '0) begin
            return 1'b1;
        end
        // result still being computed in execute
        if (issue.valid && issue.rd == addr) begin
            return 1'b0;
        end
        // load data not back yet
        if (mem_stage.valid && mem_stage.op == op_lw && mem_stage.rd == addr &&
            !(wb_en && wb_rd == addr)) begin
            return 1'b0;
        end
        return 1'b1;
    endfunction

    always_comb begin
        rs1_data  = read_data(rs1_addr);
        rs2_data  = read_data(rs2_addr);
        rs1_valid = read_valid(rs1_addr);
        rs2_valid = read_valid(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (rst_n && wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

/* source/exec.sv */
`timescale 1ns/100ps

module exec import rv_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pipe_hold,
    issue_if.executor     issue,
    output logic          flush,
    output addr_t         flush_pc,
    mem_stage_if.sender   mem_stage
);

    word_t alu_result;
    logic  taken;

    always_comb begin
        case (issue.op)
            op_add:  alu_result = issue.rs1_data + issue.rs2_data;
            op_sub:  alu_result = issue.rs1_data - issue.rs2_data;
            op_and:  alu_result = issue.rs1_data & issue.rs2_data;
            op_or:   alu_result = issue.rs1_data | issue.rs2_data;
            op_xor:  alu_result = issue.rs1_data ^ issue.rs2_data;
            op_slt: begin
                alu_result = {31'b0, $signed(issue.rs1_data) < $signed(issue.rs2_data)};
            end
            // address for loads and stores
            op_addi, op_lw, op_sw: begin
                alu_result = issue.rs1_data + issue.imm;
            end
            op_lui:  alu_result = issue.imm;
            // link value
            op_jal:  alu_result = issue.pc + 32'd4;
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        case (issue.op)
            op_beq:  taken = issue.rs1_data == issue.rs2_data;
            op_bne:  taken = issue.rs1_data != issue.rs2_data;
            op_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // redirect while the branch sits here, also during a hold
    assign flush    = issue.valid && taken;
    assign flush_pc = issue.pc + issue.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_stage.valid <= 1'b0;
        end else if (!pipe_hold) begin
            mem_stage.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipe_hold) begin
            mem_stage.op         <= issue.op;
            mem_stage.rd         <= issue.rd;
            mem_stage.result     <= alu_result;
            mem_stage.store_data <= issue.rs2_data;
        end
    end

endmodule

/* source/mem_access.sv */
`timescale 1ns/100ps

module mem_access import rv_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           mmu_wait,
    mem_stage_if.receiver  mem_stage,
    output logic           data_rden,
    output addr_t          data_raddr,
    input  logic           data_rvalid,
    input  word_t          data_rdata,
    output logic           data_wren,
    output addr_t          data_waddr,
    output word_t          data_wdata,
    output logic           wb_en,
    output reg_addr_t      wb_rd,
    output word_t          wb_data,
    output logic           pipe_hold
);

    logic is_load;
    logic is_store;
    logic sent;
    logic done;
    logic load_wait;

    assign is_load  = mem_stage.valid && mem_stage.op == op_lw;
    assign is_store = mem_stage.valid && mem_stage.op == op_sw;

    // one request per instruction
    assign data_rden  = is_load && !sent && !mmu_wait;
    assign data_raddr = mem_stage.result;
    assign data_wren  = is_store && !sent && !mmu_wait;
    assign data_waddr = mem_stage.result;
    assign data_wdata = mem_stage.store_data;

    assign load_wait = is_load && !done && !data_rvalid;
    assign pipe_hold = mmu_wait || load_wait;

    // load data is written in the cycle it arrives
    assign wb_en   = mem_stage.valid && mem_stage.rd != '0 && (!is_load || data_rvalid);
    assign wb_rd   = mem_stage.rd;
    assign wb_data = is_load ? data_rdata : mem_stage.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sent <= 1'b0;
            done <= 1'b0;
        end else if (!pipe_hold) begin
            sent <= 1'b0;
            done <= 1'b0;
        end else begin
            if (data_rden || data_wren) begin
                sent <= 1'b1;
            end
            // data came back while mmu_wait still holds the stage
            if (data_rvalid) begin
                done <= 1'b1;
            end
        end
    end

endmodule

/* source/rv_core.sv */
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mmu_wait,
    output logic  inst_rden,
    output addr_t inst_raddr,
    input  logic  inst_rvalid,
    input  word_t inst_rdata,
    output logic  data_rden,
    output addr_t data_raddr,
    input  logic  data_rvalid,
    input  word_t data_rdata,
    output logic  data_wren,
    output addr_t data_waddr,
    output word_t data_wdata
);

    logic      pipe_hold;
    logic      decode_stall;
    logic      flush;
    addr_t     flush_pc;
    logic      fetch_valid;
    addr_t     fetch_pc;
    word_t     fetch_inst;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rs1_valid;
    logic      rs2_valid;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    issue_if     issue ();
    mem_stage_if mem_stage ();

    fetch fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .pipe_hold    (pipe_hold),
        .decode_stall (decode_stall),
        .flush        (flush),
        .flush_pc     (flush_pc),
        .inst_rden    (inst_rden),
        .inst_raddr   (inst_raddr),
        .inst_rvalid  (inst_rvalid),
        .inst_rdata   (inst_rdata),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_inst   (fetch_inst)
    );

    decode decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .pipe_hold    (pipe_hold),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_inst   (fetch_inst),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_valid    (rs1_valid),
        .rs2_valid    (rs2_valid),
        .decode_stall (decode_stall),
        .issue        (issue.issuer)
    );

    reg_file reg_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_valid    (rs1_valid),
        .rs2_valid    (rs2_valid),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .issue        (issue.observer),
        .mem_stage    (mem_stage.observer)
    );

    exec exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .pipe_hold    (pipe_hold),
        .issue        (issue.executor),
        .flush        (flush),
        .flush_pc     (flush_pc),
        .mem_stage    (mem_stage.sender)
    );

    mem_access mem_access (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmu_wait     (mmu_wait),
        .mem_stage    (mem_stage.receiver),
        .data_rden    (data_rden),
        .data_raddr   (data_raddr),
        .data_rvalid  (data_rvalid),
        .data_rdata   (data_rdata),
        .data_wren    (data_wren),
        .data_waddr   (data_waddr),
        .data_wdata   (data_wdata),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .pipe_hold    (pipe_hold)
    );

endmodule

/* tests/rv_core_tb.sv */
`timescale 1ns/100ps

module rv_core_tb import rv_pkg::*; ();

    logic  clk;
    logic  rst_n;
    logic  mmu_wait;
    logic  inst_rden;
    addr_t inst_raddr;
    logic  inst_rvalid;
    word_t inst_rdata;
    logic  data_rden;
    addr_t data_raddr;
    logic  data_rvalid;
    word_t data_rdata;
    logic  data_wren;
    addr_t data_waddr;
    word_t data_wdata;

    // per-test start indexes and counts into the flat queues
    logic [127:0] t_name [$];
    bit           t_wait [$];
    int           t_inst [$];
    int           t_ninst [$];
    int           t_data [$];
    int           t_ndata [$];
    int           t_store [$];
    int           t_nstore [$];
    word_t        inst_q [$];
    addr_t        daddr_q [$];
    word_t        dword_q [$];
    addr_t        saddr_q [$];
    word_t        sdata_q [$];

    word_t imem [addr_t];
    word_t dmem [addr_t];

    bit    run_rst_n;
    bit    random_wait;
    bit    inst_req;
    addr_t inst_req_addr;
    bit    data_req;
    addr_t data_req_addr;
    bit    first_fetch;
    int    exp_first;
    int    exp_count;
    int    seen;
    int    errors;
    int    runs;
    int    failed_runs;
    bit    file_read;

    rv_core UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .mmu_wait    (mmu_wait),
        .inst_rden   (inst_rden),
        .inst_raddr  (inst_raddr),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .data_rden   (data_rden),
        .data_raddr  (data_raddr),
        .data_rvalid (data_rvalid),
        .data_rdata  (data_rdata),
        .data_wren   (data_wren),
        .data_waddr  (data_waddr),
        .data_wdata  (data_wdata)
    );

    always #50 clk = ~clk;

    // unwritten words differ for every address
    function automatic word_t fill_word(addr_t addr);
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    function automatic word_t read_imem(addr_t addr);
        if (imem.exists(addr)) begin
            return imem[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic word_t read_dmem(addr_t addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return fill_word(addr);
    endfunction

    task automatic check_addr(string sig, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %0s is %h, expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(string sig, word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %0s is %h, expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_strobe(string sig, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %0s is %b, expected %b", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic read_tests();
        int           fd;
        int           r;
        int           n;
        int           i;
        logic [127:0] tok;
        logic [127:0] mode;
        logic [1023:0] rest;
        addr_t        a;
        word_t        w;
        fd = $fopen("tests/program_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/program_tests.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == 128'("#")) begin
                r = $fgets(rest, fd);
            end else if (tok == 128'("test")) begin
                r = $fscanf(fd, "%s %s", tok, mode);
                t_name.push_back(tok);
                t_wait.push_back(mode == 128'("wait"));
            end else if (tok == 128'("inst")) begin
                r = $fscanf(fd, "%d", n);
                t_inst.push_back(inst_q.size());
                t_ninst.push_back(n);
                for (i = 0; i < n; i++) begin
                    r = $fscanf(fd, "%h", w);
                    inst_q.push_back(w);
                end
            end else if (tok == 128'("data") || tok == 128'("store")) begin
                r = $fscanf(fd, "%d", n);
                if (tok == 128'("data")) begin
                    t_data.push_back(daddr_q.size());
                    t_ndata.push_back(n);
                end else begin
                    t_store.push_back(saddr_q.size());
                    t_nstore.push_back(n);
                end
                for (i = 0; i < n; i++) begin
                    r = $fscanf(fd, "%h %h", a, w);
                    if (tok == 128'("data")) begin
                        daddr_q.push_back(a);
                        dword_q.push_back(w);
                    end else begin
                        saddr_q.push_back(a);
                        sdata_q.push_back(w);
                    end
                end
            end else begin
                $display("unknown keyword %0s in tests/program_tests.txt", tok);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // answer last edge's requests, then sample just before the next edge
    task automatic step();
        @(negedge clk);
        rst_n       = run_rst_n;
        inst_rvalid = inst_req;
        inst_rdata  = inst_req ? read_imem(inst_req_addr) : '0;
        data_rvalid = data_req;
        data_rdata  = data_req ? read_dmem(data_req_addr) : '0;
        mmu_wait    = 1'b0;
        if (random_wait && run_rst_n) begin
            mmu_wait = ($urandom % 4) == 0;
        end
        #45;
        inst_req      = rst_n && inst_rden;
        inst_req_addr = inst_raddr;
        data_req      = rst_n && data_rden;
        data_req_addr = data_raddr;
        if (mmu_wait) begin
            check_strobe("inst_rden", inst_rden, 1'b0);
            check_strobe("data_rden", data_rden, 1'b0);
            check_strobe("data_wren", data_wren, 1'b0);
        end
        if (inst_req && first_fetch) begin
            check_addr("inst_raddr", inst_raddr, reset_pc);
            first_fetch = 1'b0;
        end
        if (rst_n && data_wren) begin
            if (seen < exp_count) begin
                check_addr("data_waddr", data_waddr, saddr_q[exp_first + seen]);
                check_word("data_wdata", data_wdata, sdata_q[exp_first + seen]);
            end else begin
                $display("unexpected store number %0d to %h at %0t ns",
                         seen + 1, data_waddr, $time);
                errors++;
            end
            dmem[data_waddr] = data_wdata;
            seen++;
        end
    endtask

    task automatic run_test(int t, bit with_wait);
        int errors_before;
        int i;
        errors_before = errors;
        imem.delete();
        dmem.delete();
        for (i = 0; i < t_ninst[t]; i++) begin
            imem[reset_pc + 32'(4 * i)] = inst_q[t_inst[t] + i];
        end
        for (i = 0; i < t_ndata[t]; i++) begin
            dmem[daddr_q[t_data[t] + i]] = dword_q[t_data[t] + i];
        end
        exp_first   = t_store[t];
        exp_count   = t_nstore[t];
        seen        = 0;
        first_fetch = 1'b1;
        random_wait = 1'b0;
        run_rst_n   = 1'b0;
        // the first reset edge may still see the last run's strobes
        for (i = 0; i < 5; i++) begin
            if (i == 4) begin
                run_rst_n = 1'b1;
            end
            step();
            if (i > 0) begin
                check_strobe("inst_rden", inst_rden, 1'b0);
                check_strobe("data_rden", data_rden, 1'b0);
                check_strobe("data_wren", data_wren, 1'b0);
            end
        end
        random_wait = with_wait;
        while (seen < exp_count) begin
            step();
        end
        // the self jump must not store again
        repeat (10) step();
        runs++;
        if (errors != errors_before) begin
            failed_runs++;
        end
        $display("test %0s (%0s): %0d of %0d stores seen, %0d errors", t_name[t],
                 with_wait ? "random mmu_wait" : "no mmu_wait", seen, exp_count,
                 errors - errors_before);
    endtask

    initial begin
        int limit;
        wait (file_read);
        limit = 40 * inst_q.size() + 100;
        #(limit * 100);
        $display("watchdog expired after %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int t;
        $timeformat(-9, 0, "", 0);
        clk         = 1'b0;
        rst_n       = 1'b0;
        mmu_wait    = 1'b0;
        inst_rvalid = 1'b0;
        inst_rdata  = '0;
        data_rvalid = 1'b0;
        data_rdata  = '0;
        void'($urandom(32'h3b0161c5));
        read_tests();
        if (t_name.size() == 0) begin
            $display("no tests found in tests/program_tests.txt");
            errors++;
        end
        file_read = 1'b1;
        for (t = 0; t < t_name.size(); t++) begin
            run_test(t, 1'b0);
            if (t_wait[t]) begin
                run_test(t, 1'b1);
            end
        end
        $display("runs: %0d, failed runs: %0d, errors: %0d", runs, failed_runs, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tests/program_tests.txt */
# test <name> <plain|wait>, a wait test runs again with random mmu_wait
# inst <n> <words>, data <n> <addr word>..., store <n> <addr data>..., all hex
test arith plain
inst 20
06400093 ff900113 123451b7 20000513 00208233 402082b3
0020f333 0030e3b3 00314433 001124b3 0020a5b3 00452023
00552223 00652423 00752623 00852823 00952a23 00b52c23
00352e23 0000006f
data 0
store 8 200 0000005d 204 0000006b 208 00000060 20c 12345064
210 edcbaff9 214 00000001 218 00000000 21c 12345000
test depend wait
inst 10
06400093 f9508113 00208233 402202b3 20000513 00552023
0042c333 00652223 00452423 0000006f
data 0
store 3 200 00000064 204 00000039 208 0000005d
test load_use wait
inst 12
10000093 20000513 0000a103 002101b3 0040a203 00452023
404182b3 00352223 00552423 00052303 00652623 0000006f
data 2 100 11223344 104 00000005
store 4 200 00000005 204 22446688 208 22446683 20c 00000005
test branch wait
inst 15
20000513 00500093 00500113 00900193 00308663 00152023
00209463 00352223 00208463 00052423 00309663 00152623
00252823 00352423 0000006f
data 0
store 3 200 00000005 204 00000009 208 00000009
test jump wait
inst 9
20000513 00c000ef 00052023 00052223 00152023 008002ef
00052423 00552223 0000006f
data 0
store 2 200 00000008 204 00000018

/* all.f */
source/rv_pkg.sv
source/rv_stage_if.sv
source/fetch.sv
source/decode.sv
source/reg_file.sv
source/exec.sv
source/mem_access.sv
source/rv_core.sv
tests/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module rv_core_tb -f all.f
./obj_dir/Vrv_core_tb | tee sim.log
if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1
